/* Bender.yml */
package:
  name: cache

sources:
  - hdl/cache_pkg.sv
  - hdl/cache_ctrl_if.sv
  - hdl/plru_tracker.sv
  - hdl/cache_datapath_core.sv
  - hdl/cache_controller.sv
  - hdl/cache_top.sv
  - target: test
    files:
      - tb/cache_protocol_chk.sv
      - tb/cache_scoreboard.sv
      - tb/cache_tb.sv

/* flist.f */
hdl/cache_pkg.sv
hdl/cache_ctrl_if.sv
hdl/plru_tracker.sv
hdl/cache_datapath_core.sv
hdl/cache_controller.sv
hdl/cache_top.sv
tb/cache_protocol_chk.sv
tb/cache_scoreboard.sv
tb/cache_tb.sv

/* hdl/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller (
    input  logic          clk,
    input  logic          rst,
    input  logic          upstream_read,
    input  logic          upstream_write,
    output logic          upstream_resp,
    output logic          downstream_read,
    output logic          downstream_write,
    input  logic          downstream_resp,
    cache_ctrl_if.control ctrl
);
    import cache_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        request;
    logic        resp_next;

    assign request = upstream_read || upstream_write;

    // Only a write leaves the line dirty
    assign ctrl.new_dirty = upstream_write;

    assign downstream_write = (state == s_writeback);
    assign downstream_read  = (state == s_fill);

    always_comb begin
        state_next       = state;
        resp_next        = 1'b0;
        ctrl.tag_read    = 1'b0;
        ctrl.load_en     = 1'b0;
        ctrl.wb_addr_sel = 1'b0;
        ctrl.ld_wb       = 1'b0;
        ctrl.ld_lru      = 1'b0;
        unique case (state)
            s_idle: begin
                // The old request is still held while the response is out
                if (request && !upstream_resp) begin
                    ctrl.tag_read = 1'b1;
                    state_next    = s_lookup;
                end
            end
            s_lookup: begin
                if (ctrl.hit) begin
                    ctrl.ld_lru  = 1'b1;
                    ctrl.load_en = upstream_write;
                    resp_next    = 1'b1;
                    state_next   = s_idle;
                end else if (ctrl.victim_valid && ctrl.victim_dirty) begin
                    ctrl.ld_wb = 1'b1;
                    state_next = s_writeback;
                end else begin
                    state_next = s_fill;
                end
            end
            s_writeback: begin
                ctrl.wb_addr_sel = 1'b1;
                if (downstream_resp) begin
                    state_next = s_fill;
                end
            end
            s_fill: begin
                if (downstream_resp) begin
                    ctrl.load_en = 1'b1;
                    state_next   = s_respond;
                end
            end
            s_respond: begin
                ctrl.tag_read = 1'b1;
                state_next    = s_lookup;
            end
            default: state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= s_idle;
            upstream_resp <= 1'b0;
        end else begin
            state         <= state_next;
            upstream_resp <= resp_next;
        end
    end

endmodule

/* hdl/cache_ctrl_if.sv */
`timescale 1ns/1ps

interface cache_ctrl_if;

    // Controller to datapath
    logic tag_read;
    logic load_en;
    logic wb_addr_sel;
    logic ld_wb;
    logic ld_lru;
    logic new_dirty;

    // Datapath to controller
    logic hit;
    logic victim_valid;
    logic victim_dirty;

    modport control (
        output tag_read, load_en, wb_addr_sel, ld_wb, ld_lru, new_dirty,
        input  hit, victim_valid, victim_dirty
    );

    modport datapath (
        input  tag_read, load_en, wb_addr_sel, ld_wb, ld_lru, new_dirty,
        output hit, victim_valid, victim_dirty
    );

endinterface

/* hdl/cache_datapath_core.sv */
`timescale 1ns/1ps

module cache_datapath_core #(
    parameter int s_index = 3,
    parameter int s_way   = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t upstream_address,
    input  cache_pkg::line_t upstream_wdata,
    output cache_pkg::line_t upstream_rdata,
    input  cache_pkg::line_t downstream_rdata,
    output cache_pkg::line_t downstream_wdata,
    output cache_pkg::addr_t downstream_address,
    cache_ctrl_if.datapath   ctrl
);
    import cache_pkg::*;

    localparam int num_sets = 2**s_index;
    localparam int num_ways = 2**s_way;
    localparam int s_tag    = 32 - offset_bits - s_index;

    typedef logic [s_tag-1:0]   tag_t;
    typedef logic [s_index-1:0] index_t;

    tag_t   tag;
    index_t index;

    // Per-way storage arrays
    tag_t  tag_mem  [num_ways][num_sets];
    line_t data_mem [num_ways][num_sets];
    logic [num_ways-1:0] dirty_mem [num_sets];
    logic [num_sets-1:0][num_ways-1:0] valid_mem;

    // Synchronous read outputs
    tag_t  tag_q  [num_ways];
    line_t data_q [num_ways];
    logic [num_ways-1:0] valid_q;
    logic [num_ways-1:0] dirty_q;

    logic [num_ways-1:0] hits;
    logic [num_ways-1:0] way;
    tag_t  sel_tag;
    line_t sel_line;
    line_t fill_data;

    assign tag   = upstream_address[31:offset_bits+s_index];
    assign index = upstream_address[offset_bits+s_index-1:offset_bits];

    // Dirty is set exactly when the upstream side writes
    assign fill_data = ctrl.new_dirty ? upstream_wdata : downstream_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (ctrl.load_en && way[w]) begin
                    valid_mem[index][w] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (ctrl.load_en && way[w]) begin
                tag_mem[w][index]   <= tag;
                data_mem[w][index]  <= fill_data;
                dirty_mem[index][w] <= ctrl.new_dirty;
            end
            if (ctrl.tag_read) begin
                tag_q[w]   <= tag_mem[w][index];
                data_q[w]  <= data_mem[w][index];
                dirty_q[w] <= dirty_mem[index][w];
                valid_q[w] <= valid_mem[index][w];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hits[w] = valid_q[w] && (tag_q[w] == tag);
        end
    end

    plru_tracker #(
        .s_index(s_index),
        .s_way  (s_way)
    ) plru (
        .clk,
        .rst,
        .index,
        .read  (ctrl.tag_read),
        .update(ctrl.ld_lru),
        .hits,
        .valids(valid_q),
        .way
    );

    // Hit way on a hit, victim way otherwise
    always_comb begin
        sel_tag  = '0;
        sel_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (way[w]) begin
                sel_tag  = tag_q[w];
                sel_line = data_q[w];
            end
        end
    end

    assign ctrl.hit          = |hits;
    assign ctrl.victim_valid = |(valid_q & way);
    assign ctrl.victim_dirty = |(dirty_q & way);

    assign upstream_rdata = sel_line;

    always_ff @(posedge clk) begin
        if (ctrl.ld_wb) begin
            downstream_wdata <= sel_line;
        end
    end

    assign downstream_address = ctrl.wb_addr_sel ?
        {sel_tag, index, {offset_bits{1'b0}}} :
        {upstream_address[31:offset_bits], {offset_bits{1'b0}}};

endmodule

/* hdl/cache_pkg.sv */
package cache_pkg;

    // Byte offset within a line, 32-byte lines
    localparam int offset_bits = 5;

    // Full line payload
    localparam int line_bits = 256;

    // Byte address as seen on both sides of the cache
    typedef logic [31:0] addr_t;

    // One cache line of data
    typedef logic [line_bits-1:0] line_t;

    // Controller sequencing
    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_writeback,
        s_fill,
        s_respond
    } ctrl_state_e;

endpackage

/* hdl/cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
    parameter int s_index = 3,
    parameter int s_way   = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t upstream_address,
    input  logic             upstream_read,
    input  logic             upstream_write,
    input  cache_pkg::line_t upstream_wdata,
    output cache_pkg::line_t upstream_rdata,
    output logic             upstream_resp,
    output cache_pkg::addr_t downstream_address,
    output logic             downstream_read,
    output logic             downstream_write,
    output cache_pkg::line_t downstream_wdata,
    input  cache_pkg::line_t downstream_rdata,
    input  logic             downstream_resp
);

    cache_ctrl_if ctrl ();

    cache_controller controller (
        .clk,
        .rst,
        .upstream_read,
        .upstream_write,
        .upstream_resp,
        .downstream_read,
        .downstream_write,
        .downstream_resp,
        .ctrl(ctrl.control)
    );

    cache_datapath_core #(
        .s_index(s_index),
        .s_way  (s_way)
    ) datapath (
        .clk,
        .rst,
        .upstream_address,
        .upstream_wdata,
        .upstream_rdata,
        .downstream_rdata,
        .downstream_wdata,
        .downstream_address,
        .ctrl(ctrl.datapath)
    );

endmodule

/* hdl/plru_tracker.sv */
`timescale 1ns/1ps

module plru_tracker #(
    parameter int s_index = 3,
    parameter int s_way   = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [s_index-1:0]    index,
    input  logic                  read,
    input  logic                  update,
    input  logic [2**s_way-1:0]   hits,
    input  logic [2**s_way-1:0]   valids,
    output logic [2**s_way-1:0]   way
);
    localparam int num_sets = 2**s_index;
    localparam int num_ways = 2**s_way;

    logic [num_sets-1:0][num_ways-2:0] lru_mem;
    logic [num_ways-2:0] lru_q;
    logic [num_ways-2:0] new_lru;
    logic [s_way-1:0]    tree_idx;
    logic [s_way-1:0]    sel_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_mem <= '0;
        end else if (update) begin
            lru_mem[index] <= new_lru;
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            lru_q <= lru_mem[index];
        end
    end

    // Walk the tree, each bit points toward the older half
    always_comb begin
        int node;
        tree_idx = '0;
        node = 0;
        for (int l = 0; l < s_way; l++) begin
            tree_idx = (tree_idx << 1) | s_way'(lru_q[node]);
            node = 2*node + 1 + int'(lru_q[node]);
        end
    end

    // Later loops win, so a hit beats the lowest invalid way which beats the tree
    always_comb begin
        sel_idx = tree_idx;
        for (int w = num_ways-1; w >= 0; w--) begin
            if (!valids[w]) begin
                sel_idx = s_way'(w);
            end
        end
        for (int w = num_ways-1; w >= 0; w--) begin
            if (hits[w]) begin
                sel_idx = s_way'(w);
            end
        end
    end

    assign way = num_ways'(1) << sel_idx;

    // Point every node on the path away from the accessed way
    always_comb begin
        int node;
        new_lru = lru_q;
        node = 0;
        for (int l = 0; l < s_way; l++) begin
            new_lru[node] = ~sel_idx[s_way-1-l];
            node = 2*node + 1 + int'(sel_idx[s_way-1-l]);
        end
    end

endmodule

/* tb/cache_protocol_chk.sv */
`timescale 1ns/1ps

module cache_protocol_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   upstream_resp,
    input logic                   downstream_read,
    input logic                   downstream_write,
    input logic                   downstream_resp,
    input cache_pkg::addr_t       downstream_address,
    input cache_pkg::ctrl_state_e state
);
    import cache_pkg::*;

    int violations;

    initial violations = 0;

    upstream_pulse: assert property (@(posedge clk) disable iff (rst)
        upstream_resp |=> !upstream_resp)
    else begin
        $error("upstream_resp held longer than one cycle");
        violations++;
    end

    downstream_pulse: assert property (@(posedge clk) disable iff (rst)
        downstream_resp |=> !downstream_resp)
    else begin
        $error("downstream_resp held longer than one cycle");
        violations++;
    end

    one_direction: assert property (@(posedge clk) disable iff (rst)
        !(downstream_read && downstream_write))
    else begin
        $error("downstream_read and downstream_write high together");
        violations++;
    end

    line_aligned: assert property (@(posedge clk) disable iff (rst)
        (downstream_read || downstream_write) |-> downstream_address[offset_bits-1:0] == '0)
    else begin
        $error("downstream_address not line aligned");
        violations++;
    end

    // The re-read after a fill has to hit
    refill_hits: assert property (@(posedge clk) disable iff (rst)
        state == s_respond |-> ##2 upstream_resp)
    else begin
        $error("no upstream_resp two cycles after s_respond");
        violations++;
    end

endmodule

bind cache_top cache_protocol_chk protocol_chk (
    .clk,
    .rst,
    .upstream_resp,
    .downstream_read,
    .downstream_write,
    .downstream_resp,
    .downstream_address,
    .state(controller.state)
);

/* tb/cache_scoreboard.sv */
`timescale 1ns/1ps

module cache_scoreboard (
    input  logic             clk,
    input  logic             rst,
    input  logic             expect_hit,
    input  cache_pkg::addr_t upstream_address,
    input  logic             upstream_read,
    input  logic             upstream_write,
    input  cache_pkg::line_t upstream_wdata,
    input  cache_pkg::line_t upstream_rdata,
    input  logic             upstream_resp,
    input  cache_pkg::addr_t downstream_address,
    input  logic             downstream_read,
    input  logic             downstream_write,
    input  cache_pkg::line_t downstream_wdata,
    input  logic             downstream_resp,
    output int               check_count,
    output int               error_count
);
    import cache_pkg::*;

    // Latest upstream-written data per line address
    line_t model [addr_t];
    logic  busy;
    logic  downstream_seen;
    int    cycles;
    int    quiet_cycles;

    // Contents of a line the memory has never been given
    function automatic line_t initial_line(input addr_t line_addr);
        line_t data;
        for (int i = 0; i < line_bits / 32; i++) begin
            data[32*i +: 32] = line_addr ^ (32'h9e3779b9 * (i + 1));
        end
        return data;
    endfunction

    task automatic check_low(input string name, input logic value);
        check_count++;
        if (value !== 1'b0) begin
            error_count++;
            $display("error %s: expected 0x0, actual 0x%h", name, value);
        end
    endtask

    task automatic compare(input string name, input addr_t line_addr,
                           input line_t expected, input line_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s (line 0x%h): expected 0x%h, actual 0x%h",
                     name, line_addr, expected, actual);
        end
    endtask

    initial begin
        check_count  = 0;
        error_count  = 0;
        busy         = 1'b0;
        quiet_cycles = 0;
    end

    // Sample mid-cycle away from both clock edges
    always @(negedge clk) begin
        addr_t line_addr;
        line_t expected;
        if (rst || quiet_cycles > 0) begin
            check_low("upstream_resp", upstream_resp);
            check_low("downstream_read", downstream_read);
            check_low("downstream_write", downstream_write);
        end
        if (rst) begin
            quiet_cycles = 4;
            busy         = 1'b0;
        end else begin
            if (quiet_cycles > 0) begin
                quiet_cycles--;
            end
            if (busy) begin
                cycles++;
            end else if (upstream_resp) begin
                error_count++;
                $display("upstream_resp pulsed with no request pending");
            end else if (upstream_read || upstream_write) begin
                busy            = 1'b1;
                cycles          = 0;
                downstream_seen = 1'b0;
            end
            if (busy && (downstream_read || downstream_write)) begin
                downstream_seen = 1'b1;
            end
            // A fill always fetches the requested line
            if (busy && downstream_read && downstream_resp) begin
                line_addr = {upstream_address[31:offset_bits], {offset_bits{1'b0}}};
                check_count++;
                if (downstream_address !== line_addr) begin
                    error_count++;
                    $display("error downstream_address: expected 0x%h, actual 0x%h",
                             line_addr, downstream_address);
                end
            end
            if (downstream_write && downstream_resp) begin
                if (!model.exists(downstream_address)) begin
                    check_count++;
                    error_count++;
                    $display("write-back of line 0x%h that was never written upstream",
                             downstream_address);
                end else begin
                    compare("downstream_wdata", downstream_address,
                            model[downstream_address], downstream_wdata);
                end
            end
            if (busy && upstream_resp) begin
                line_addr = {upstream_address[31:offset_bits], {offset_bits{1'b0}}};
                if (upstream_write) begin
                    model[line_addr] = upstream_wdata;
                end else begin
                    expected = model.exists(line_addr) ? model[line_addr] :
                                                         initial_line(line_addr);
                    compare("upstream_rdata", line_addr, expected, upstream_rdata);
                end
                if (expect_hit) begin
                    check_count++;
                    if (cycles != 2 || downstream_seen) begin
                        error_count++;
                        $display("expected a hit at 0x%h: %0d cycles, downstream used %0d",
                                 upstream_address, cycles, downstream_seen);
                    end
                end
                busy = 1'b0;
            end
        end
    end

endmodule

/* tb/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    localparam int s_index        = 3;
    localparam int s_way          = 2;
    localparam int num_ways       = 2**s_way;
    localparam int n_repeat       = 24;
    localparam int n_random       = 400;
    localparam int n_requests     = 2*num_ways + 2*n_repeat + n_random;
    localparam int timeout_cycles = 64 * n_requests;

    logic  clk;
    logic  rst;
    addr_t upstream_address;
    logic  upstream_read;
    logic  upstream_write;
    line_t upstream_wdata;
    line_t upstream_rdata;
    logic  upstream_resp;
    addr_t downstream_address;
    logic  downstream_read;
    logic  downstream_write;
    line_t downstream_wdata;
    line_t downstream_rdata;
    logic  downstream_resp;
    logic  expect_hit;

    int seed       = 32'hd798;
    int delay_seed = 32'hd798;
    int cycle_count;
    int sb_checks;
    int sb_errors;
    int tests_run;
    int tests_bad;
    int errors_before;

    // Downstream memory holds only lines that were written back
    line_t mem [addr_t];

    cache_top #(
        .s_index(s_index),
        .s_way  (s_way)
    ) i_cache_top (
        .clk,
        .rst,
        .upstream_address,
        .upstream_read,
        .upstream_write,
        .upstream_wdata,
        .upstream_rdata,
        .upstream_resp,
        .downstream_address,
        .downstream_read,
        .downstream_write,
        .downstream_wdata,
        .downstream_rdata,
        .downstream_resp
    );

    cache_scoreboard i_scoreboard (
        .clk,
        .rst,
        .expect_hit,
        .upstream_address,
        .upstream_read,
        .upstream_write,
        .upstream_wdata,
        .upstream_rdata,
        .upstream_resp,
        .downstream_address,
        .downstream_read,
        .downstream_write,
        .downstream_wdata,
        .downstream_resp,
        .check_count(sb_checks),
        .error_count(sb_errors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("run did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Memory answers 1 to 4 cycles after a request shows up
    initial begin
        int wait_cycles;
        downstream_resp  = 1'b0;
        downstream_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            downstream_resp = 1'b0;
            if (!rst && (downstream_read || downstream_write)) begin
                wait_cycles = 1 + {$random(delay_seed)} % 4;
                repeat (wait_cycles) @(posedge clk);
                #1;
                if (downstream_write) begin
                    mem[downstream_address] = downstream_wdata;
                end else if (mem.exists(downstream_address)) begin
                    downstream_rdata = mem[downstream_address];
                end else begin
                    downstream_rdata = i_scoreboard.initial_line(downstream_address);
                end
                downstream_resp = 1'b1;
            end
        end
    end

    function automatic int total_errors();
        return sb_errors + i_cache_top.protocol_chk.violations;
    endfunction

    // Tags from a small pool in sets 2 and 5
    function automatic addr_t pool_address(input int tag_sel, input int set_sel,
                                           input int offset);
        addr_t tag;
        tag = 32'h2c0 + 32'(tag_sel) * 32'h35;
        return (tag << (offset_bits + s_index)) | (addr_t'(set_sel) << offset_bits) |
               addr_t'(offset);
    endfunction

    function automatic addr_t random_address();
        int tag_sel;
        int set_sel;
        tag_sel = {$random(seed)} % 8;
        set_sel = ({$random(seed)} % 2) ? 5 : 2;
        return pool_address(tag_sel, set_sel, {$random(seed)} % 32);
    endfunction

    // Holds the request through the response cycle and returns 1 ns after the next edge
    task automatic access(input logic write, input addr_t address, input logic hit_expected);
        line_t data;
        for (int i = 0; i < line_bits / 32; i++) begin
            data[32*i +: 32] = $random(seed);
        end
        upstream_address = address;
        upstream_read    = !write;
        upstream_write   = write;
        upstream_wdata   = data;
        expect_hit       = hit_expected;
        do begin
            @(posedge clk);
            #1;
        end while (!upstream_resp);
        @(posedge clk);
        #1;
        upstream_read  = 1'b0;
        upstream_write = 1'b0;
        expect_hit     = 1'b0;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = total_errors() - errors_before;
        tests_run++;
        if (errs != 0) begin
            tests_bad++;
        end
        $display("%-14s %s, %0d errors", name, (errs == 0) ? "pass" : "FAIL", errs);
        errors_before = total_errors();
    endtask

    initial begin
        addr_t address;
        tests_run        = 0;
        tests_bad        = 0;
        errors_before    = 0;
        rst              = 1'b1;
        upstream_address = '0;
        upstream_read    = 1'b0;
        upstream_write   = 1'b0;
        upstream_wdata   = '0;
        expect_hit       = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        end_test("reset_quiet");

        // Invalid ways fill first, so every tag is still resident afterwards
        for (int k = 0; k < num_ways; k++) begin
            access(1'b0, pool_address(k, 2, 0), 1'b0);
        end
        for (int k = 0; k < num_ways; k++) begin
            access(k[0], pool_address(k, 2, 4*k), 1'b1);
        end
        end_test("fill_then_hit");

        for (int n = 0; n < n_repeat; n++) begin
            address = random_address();
            access($random(seed) & 1, address, 1'b0);
            access($random(seed) & 1, address, 1'b1);
        end
        end_test("repeat_hit");

        for (int n = 0; n < n_random; n++) begin
            access($random(seed) & 1, random_address(), 1'b0);
        end
        end_test("random_mix");

        repeat (4) @(posedge clk);
        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, sb_checks, total_errors());
        if (total_errors() == 0 && tests_bad == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
